//--- hw/cpu_cfg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core-wide address and instruction widths
// and the relative jump encoding fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package cpu_cfg_pkg;

   // byte address and instruction word widths
   localparam int ADDR_W = 32;
   localparam int INSN_W = 32;
   localparam int PC_W   = ADDR_W - 2; // the PC counts words, the low two address bits are 0

   // relative jump major opcode sits in the top six bits of the word
   localparam logic [5:0] OPC_JMPREL = 6'h01;
   localparam int OPC_MSB = 31;
   localparam int OPC_LSB = 26;

   localparam int JMP_COND_BIT = 25; // set means taken only when the condition flag is 1
   localparam int JMP_LINK_BIT = 24; // set means the decoder writes a return address

   // signed word offset in bits 23 down to 0
   localparam int JMP_OFS_W = 24;

endpackage

`default_nettype wire

//--- hw/ifetch_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch control with bus handshake, next-PC
// source selection and pending far redirect
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module ifetch_ctrl
   import cpu_cfg_pkg::*;
   import ifetch_types_pkg::*;
(
   input  logic            clk,
   input  logic            arst_n,
   input  far_jmp_t        far_jmp,      // one-cycle redirect pulse
   input  jmp_info_t       jmp_info,     // predecode of the word on the bus
   input  logic            ibus_valid,
   input  logic            buf_in_ready, // pipe buffer can take a packet
   output logic            ibus_ready,
   output logic            pc_load,      // a bus transfer happens on this edge
   output logic [1:0]      pc_sel,
   output logic [PC_W-1:0] far_target,
   output logic            jmp_ready     // no redirect is waiting
);

   far_jmp_t pend_q;  // redirect that arrived while no transfer took place
   far_jmp_t far_eff; // redirect that applies to the current transfer

   // the bus is held off in reset and afterwards only moves when the buffer has room
   assign ibus_ready = arst_n & buf_in_ready;
   assign pc_load    = ibus_valid & ibus_ready;
   assign jmp_ready  = ~pend_q.valid;

   // a waiting redirect wins, otherwise a fresh pulse is used directly
   // a pulse that arrives while one is pending is simply dropped here
   assign far_eff    = pend_q.valid ? pend_q : far_jmp;
   assign far_target = far_eff.target;

   // far redirect beats a taken relative jump, which beats the sequential path
   always_comb begin
      if (far_eff.valid) begin
         pc_sel = PC_SEL_FAR;
      end else if (jmp_info.taken) begin
         pc_sel = PC_SEL_REL;
      end else begin
         pc_sel = PC_SEL_SEQ;
      end
   end

   // the pending redirect is captured on an idle cycle and dropped once a transfer uses it
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pend_q <= '0;
      end else if (pc_load) begin
         pend_q.valid <= 1'b0;      // the redirect went into the PC on this edge
      end else if (far_jmp.valid && jmp_ready) begin
         pend_q <= far_jmp;         // keep it until the bus moves again
      end
   end

endmodule

`default_nettype wire

//--- hw/ifetch_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction fetch stage top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module ifetch_top
   import cpu_cfg_pkg::*;
   import ifetch_types_pkg::*;
#(
   parameter logic [ADDR_W-1:0] RESET_VECTOR = 32'h0000_0100 // byte address fetched after reset
)(
   input  logic              clk,
   input  logic              arst_n,
   // instruction bus
   input  logic              ibus_valid,
   input  logic [INSN_W-1:0] ibus_insn,
   output logic              ibus_ready,
   output logic [ADDR_W-1:0] ibus_addr,
   // condition flag and far redirect
   input  logic              cc,
   input  far_jmp_t          far_jmp,
   output logic              jmp_ready,
   // decoder
   output logic              dec_valid,
   output fetch_pkt_t        dec_pkt,
   input  logic              dec_ready
);

   jmp_info_t       jmp_info;
   logic            op_jmprel;
   logic            jmprel_link;
   logic            pc_load;
   logic [1:0]      pc_sel;
   logic [PC_W-1:0] far_target;
   logic [PC_W-1:0] pc_q;
   logic [PC_W-1:0] pc_nxt;
   logic            buf_in_ready;
   fetch_pkt_t      fetch_pkt;

   // the bus is told where the word after the current one lives
   assign ibus_addr = {pc_nxt, 2'b00};

   // the word on the bus belongs to the PC register value
   assign fetch_pkt = '{insn:        ibus_insn,
                        pc:          pc_q,
                        op_jmprel:   op_jmprel,
                        jmprel_link: jmprel_link};

   ifetch_ctrl u_ifetch_ctrl (
      .clk          (clk),
      .arst_n       (arst_n),
      .far_jmp      (far_jmp),
      .jmp_info     (jmp_info),
      .ibus_valid   (ibus_valid),
      .buf_in_ready (buf_in_ready),
      .ibus_ready   (ibus_ready),
      .pc_load      (pc_load),
      .pc_sel       (pc_sel),
      .far_target   (far_target),
      .jmp_ready    (jmp_ready)
   );

   pc_gen #(.RESET_VECTOR(RESET_VECTOR)) u_pc_gen (
      .clk        (clk),
      .arst_n     (arst_n),
      .pc_load    (pc_load),
      .pc_sel     (pc_sel),
      .far_target (far_target),
      .jmp_info   (jmp_info),
      .pc_q       (pc_q),
      .pc_nxt     (pc_nxt)
   );

   predecode u_predecode (
      .insn        (ibus_insn),
      .cc          (cc),
      .jmp_info    (jmp_info),
      .op_jmprel   (op_jmprel),
      .jmprel_link (jmprel_link)
   );

   // bus valid feeds the buffer directly, its ready goes back through control
   pipe_buf u_pipe_buf (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (ibus_valid),
      .in_pkt    (fetch_pkt),
      .in_ready  (buf_in_ready),
      .out_valid (dec_valid),
      .out_pkt   (dec_pkt),
      .out_ready (dec_ready)
   );

endmodule

`default_nettype wire

//--- hw/ifetch_types_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch packet, jump info and redirect structs
// plus the next-PC source select codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package ifetch_types_pkg;

   import cpu_cfg_pkg::*;

   // what the decoder receives for every fetched word
   typedef struct packed {
      logic [INSN_W-1:0] insn;        // raw instruction word
      logic [PC_W-1:0]   pc;          // word address it was fetched from
      logic              op_jmprel;   // word is a relative jump
      logic              jmprel_link; // relative jump also writes a return address
   } fetch_pkt_t;

   // result of predecoding the word on the instruction bus
   typedef struct packed {
      logic            taken;  // relative jump whose condition holds
      logic [PC_W-1:0] offset; // word offset, already sign extended to the PC width
   } jmp_info_t;

   // far redirect request from later in the pipeline
   typedef struct packed {
      logic            valid;
      logic [PC_W-1:0] target; // word address to continue from
   } far_jmp_t;

   // next-PC source codes driven by fetch control into the PC generator
   localparam logic [1:0] PC_SEL_SEQ = 2'd0; // pc plus one
   localparam logic [1:0] PC_SEL_REL = 2'd1; // pc plus predecoded offset
   localparam logic [1:0] PC_SEL_FAR = 2'd2; // far redirect target

endpackage

`default_nettype wire

//--- hw/pc_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// program counter register and next-PC mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module pc_gen
   import cpu_cfg_pkg::*;
   import ifetch_types_pkg::*;
#(
   parameter logic [ADDR_W-1:0] RESET_VECTOR = 32'h0000_0100 // byte address of the first word
)(
   input  logic            clk,
   input  logic            arst_n,
   input  logic            pc_load,    // load pc_nxt on this edge
   input  logic [1:0]      pc_sel,     // next-PC source
   input  logic [PC_W-1:0] far_target,
   input  jmp_info_t       jmp_info,
   output logic [PC_W-1:0] pc_q,       // word address of the word on the bus
   output logic [PC_W-1:0] pc_nxt      // word address fetched after this one
);

   localparam logic [PC_W-1:0] RESET_PC = RESET_VECTOR[ADDR_W-1:2]; // byte to word address

   logic [PC_W-1:0] pc_seq;
   logic [PC_W-1:0] pc_rel;

   // candidate next addresses
   assign pc_seq = pc_q + PC_W'(1);
   assign pc_rel = pc_q + jmp_info.offset; // offset is signed, wraps like the hardware adder

   always_comb begin
      case (pc_sel)
         PC_SEL_REL: pc_nxt = pc_rel;
         PC_SEL_FAR: pc_nxt = far_target;
         default:    pc_nxt = pc_seq; // sequential, and the unused code
      endcase
   end

   // the PC only moves on a bus transfer
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc_q <= RESET_PC;
      end else if (pc_load) begin
         pc_q <= pc_nxt;
      end
   end

endmodule

`default_nettype wire

//--- hw/pipe_buf.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one-entry valid/ready fetch packet register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module pipe_buf
   import ifetch_types_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       in_valid,
   input  fetch_pkt_t in_pkt,
   output logic       in_ready,
   output logic       out_valid,
   output fetch_pkt_t out_pkt,
   input  logic       out_ready
);

   logic       full_q; // the stage holds a packet not yet taken by the decoder
   fetch_pkt_t pkt_q;
   logic       cas;    // capture strobe, a packet moves in on this edge

   // room exists when empty or when the held packet leaves on the same edge
   assign in_ready = ~full_q | out_ready;
   assign cas      = in_valid & in_ready;

   // occupancy flag
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         full_q <= 1'b0;
      end else if (cas) begin
         full_q <= 1'b1;      // refilled, possibly while the old packet drains
      end else if (out_ready) begin
         full_q <= 1'b0;      // drained with nothing new behind it
      end
   end

   // packet payload only changes on capture so it holds under back-pressure
   always_ff @(posedge clk) begin
      if (cas) begin
         pkt_q <= in_pkt;
      end
   end

   assign out_valid = full_q;
   assign out_pkt   = pkt_q;

endmodule

`default_nettype wire

//--- hw/predecode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// relative jump predecoder with condition,
// offset extension and link bit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module predecode
   import cpu_cfg_pkg::*;
   import ifetch_types_pkg::*;
(
   input  logic [INSN_W-1:0] insn,        // word currently on the instruction bus
   input  logic              cc,          // condition flag from the status register
   output jmp_info_t         jmp_info,
   output logic              op_jmprel,
   output logic              jmprel_link
);

   logic [5:0]           opc;
   logic                 is_jmprel;
   logic                 is_cond;
   logic                 cond_ok;
   logic [JMP_OFS_W-1:0] ofs_raw;
   logic [PC_W-1:0]      ofs_ext;

   // field extraction
   assign opc     = insn[OPC_MSB:OPC_LSB];
   assign ofs_raw = insn[JMP_OFS_W-1:0];
   assign is_cond = insn[JMP_COND_BIT];

   // only the major opcode is checked, the rest of the word is the jump itself
   assign is_jmprel = (opc == OPC_JMPREL);

   // unconditional jumps always pass, conditional ones need the flag set
   assign cond_ok = ~is_cond | cc;

   // widen the 24 bit word offset to the PC width with its sign bit
   assign ofs_ext = {{(PC_W-JMP_OFS_W){ofs_raw[JMP_OFS_W-1]}}, ofs_raw};

   // info for fetch control and the PC generator
   assign jmp_info.taken  = is_jmprel & cond_ok;
   assign jmp_info.offset = ofs_ext; // meaningless unless taken is high

   // bits that travel with the packet to the decoder
   assign op_jmprel   = is_jmprel;
   assign jmprel_link = is_jmprel & insn[JMP_LINK_BIT]; // link is reported even if not taken

endmodule

`default_nettype wire

//--- ifetch.f
hw/cpu_cfg_pkg.sv
hw/ifetch_types_pkg.sv
hw/ifetch_ctrl.sv
hw/pc_gen.sv
hw/predecode.sv
hw/pipe_buf.sv
hw/ifetch_top.sv
verification/tb_ifetch_bus.sv
verification/tb_ifetch.sv

//--- verification/tb_ifetch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch stage testbench with clock, reset,
// stimulus, reference model and assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module tb_ifetch
   import cpu_cfg_pkg::*;
   import ifetch_types_pkg::*;
();

   localparam logic [ADDR_W-1:0] RESET_VECTOR = 32'h0000_0100;
   localparam logic [PC_W-1:0]   RESET_PC     = RESET_VECTOR[ADDR_W-1:2];
   localparam int                PKT_TARGET   = 600;   // packets to accept before stopping
   localparam int                RUN_LIMIT    = 30000; // cycles before the run is abandoned

   logic              clk;
   logic              arst_n;
   logic              ibus_valid;
   logic [INSN_W-1:0] ibus_insn;
   logic              ibus_ready;
   logic [ADDR_W-1:0] ibus_addr;
   logic              cc;
   far_jmp_t          far_jmp;
   logic              jmp_ready;
   logic              dec_valid;
   fetch_pkt_t        dec_pkt;
   logic              dec_ready;

   logic [INSN_W-1:0] image [0:255]; // reference copy of the program image
   fetch_pkt_t        exp_q [$];     // packets transferred but not yet accepted
   fetch_pkt_t        exp_head;
   int                exp_cnt;
   logic [PC_W-1:0]   ref_pc;        // word expected on the bus
   logic [PC_W-1:0]   ref_nxt;       // word expected after the current one
   logic              ref_pend_v;    // redirect waiting for a transfer
   logic [PC_W-1:0]   ref_pend_t;
   logic              xfer;
   int                errors;
   int                accepted;
   int                cycles;
   int                seed;
   logic              timed_out;

   ifetch_top #(.RESET_VECTOR(RESET_VECTOR)) u_ifetch_top (
      .clk        (clk),
      .arst_n     (arst_n),
      .ibus_valid (ibus_valid),
      .ibus_insn  (ibus_insn),
      .ibus_ready (ibus_ready),
      .ibus_addr  (ibus_addr),
      .cc         (cc),
      .far_jmp    (far_jmp),
      .jmp_ready  (jmp_ready),
      .dec_valid  (dec_valid),
      .dec_pkt    (dec_pkt),
      .dec_ready  (dec_ready)
   );

   tb_ifetch_bus #(.RESET_VECTOR(RESET_VECTOR)) u_bus (
      .clk        (clk),
      .arst_n     (arst_n),
      .ibus_ready (ibus_ready),
      .ibus_addr  (ibus_addr),
      .ibus_valid (ibus_valid),
      .ibus_insn  (ibus_insn)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // program word for each image slot; plain words never carry the jump opcode
   function automatic logic [INSN_W-1:0] image_word(input int i);
      logic [7:0] a;
      a = i[7:0];
      if (i >= 8'he0) begin
         return {6'h30, 2'b11, a, ~a, a ^ 8'h5a}; // straight code in the far jump landing zone
      end else if (i % 16 == 5) begin
         return {OPC_JMPREL, 1'b0, 1'b0, 24'd7};          // unconditional, no link
      end else if (i % 16 == 13) begin
         return {OPC_JMPREL, 1'b1, 1'b1, 24'hff_ffec};    // conditional with link going back 20
      end else if (i % 32 == 9) begin
         return {OPC_JMPREL, 1'b1, 1'b0, 24'd2};          // conditional, no link
      end else if (i % 32 == 25) begin
         return {OPC_JMPREL, 1'b0, 1'b1, 24'd11};         // unconditional with link
      end
      return {6'h30, 2'b00, a, ~a, a};
   endfunction

   // next word by the fetch rules in order of pending redirect, fresh pulse, taken jump and plus one
   always_comb begin
      logic [INSN_W-1:0] w;
      logic              taken;
      w     = image[ref_pc[7:0]];
      taken = (w[31:26] == OPC_JMPREL) && (!w[JMP_COND_BIT] || cc);
      if (ref_pend_v) begin
         ref_nxt = ref_pend_t;
      end else if (far_jmp.valid) begin
         ref_nxt = far_jmp.target;
      end else if (taken) begin
         ref_nxt = ref_pc + {{(PC_W-JMP_OFS_W){w[JMP_OFS_W-1]}}, w[JMP_OFS_W-1:0]};
      end else begin
         ref_nxt = ref_pc + 1'b1;
      end
   end

   assign xfer = ibus_valid && ibus_ready;

   // reference model keeping a queue of predicted packets in transfer order
   always @(posedge clk or negedge arst_n) begin
      fetch_pkt_t p;
      if (!arst_n) begin
         ref_pc     <= RESET_PC;
         ref_pend_v <= 1'b0;
         ref_pend_t <= '0;
         exp_q.delete();
         exp_head   <= '0;
         exp_cnt    <= 0;
      end else begin
         if (dec_valid && dec_ready && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            accepted = accepted + 1;
         end
         if (xfer) begin
            p.insn        = image[ref_pc[7:0]];
            p.pc          = ref_pc;
            p.op_jmprel   = (p.insn[31:26] == OPC_JMPREL);
            p.jmprel_link = p.op_jmprel && p.insn[JMP_LINK_BIT];
            exp_q.push_back(p);
            ref_pc     <= ref_nxt;
            ref_pend_v <= 1'b0; // any redirect is used up by this transfer
         end else if (far_jmp.valid && !ref_pend_v) begin
            ref_pend_v <= 1'b1;
            ref_pend_t <= far_jmp.target;
         end
         exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
         exp_cnt  <= exp_q.size();
      end
   end

   a_reset: assert property (@(posedge clk) !arst_n |-> !dec_valid && !ibus_ready)
      else begin
         errors++;
         $display("** Error [reset] expected valid 0 ready 0, actual valid %b ready %b",
                  dec_valid, ibus_ready);
      end

   a_packet: assert property (@(posedge clk) disable iff (!arst_n)
      dec_valid && dec_ready |-> exp_cnt > 0 && dec_pkt == exp_head)
      else begin
         errors++;
         $display("** Error [packet] expected %h (%0d queued), actual %h",
                  exp_head, exp_cnt, dec_pkt);
      end

   a_hold: assert property (@(posedge clk) disable iff (!arst_n)
      dec_valid && !dec_ready |=> dec_valid && $stable(dec_pkt))
      else begin
         errors++;
         $display("** Error [hold] expected valid 1 pkt %h, actual valid %b pkt %h",
                  $past(dec_pkt), dec_valid, dec_pkt);
      end

   a_bus_addr: assert property (@(posedge clk) disable iff (!arst_n)
      xfer |-> ibus_addr == {ref_nxt, 2'b00})
      else begin
         errors++;
         $display("** Error [bus_addr] expected %h, actual %h", {ref_nxt, 2'b00}, ibus_addr);
      end

   // the buffer takes a word whenever it is empty or the decoder takes its packet
   a_bus_ready: assert property (@(posedge clk) disable iff (!arst_n)
      ibus_ready == (!dec_valid || dec_ready))
      else begin
         errors++;
         $display("** Error [bus_ready] expected %b, actual %b", !dec_valid || dec_ready,
                  ibus_ready);
      end

   a_jmp_ready: assert property (@(posedge clk) disable iff (!arst_n)
      jmp_ready == !ref_pend_v)
      else begin
         errors++;
         $display("** Error [jmp_ready] expected %b, actual %b", !ref_pend_v, jmp_ready);
      end

   // the packet count steps through plain flow, random cc and then back-pressure with redirects
   task automatic drive_cycle();
      far_jmp = '0;
      if (accepted < 100) begin
         cc        = 1'b0;
         dec_ready = 1'b1;
      end else if (accepted < 200) begin
         cc        = $random(seed);
         dec_ready = 1'b1;
      end else begin
         cc        = $random(seed);
         dec_ready = ($random(seed) & 3) != 0;
         if (($random(seed) & 15) == 0) begin
            far_jmp.valid  = 1'b1;
            far_jmp.target = ($random(seed) & 30'h3fff_ff1f) | 30'h0e0;
         end
      end
   endtask

   initial begin
      int k;
      seed      = 32'h6b1d034f;
      errors    = 0;
      accepted  = 0;
      cycles    = 0;
      timed_out = 1'b0;
      arst_n    = 1'b0;
      cc        = 1'b0;
      far_jmp   = '0;
      dec_ready = 1'b0;
      for (k = 0; k < 256; k++) begin
         image[k]       = image_word(k);
         u_bus.image[k] = image_word(k);
      end
      repeat (5) @(negedge clk);
      arst_n = 1'b1;
      // first packet must show up within a bounded time
      while (!dec_valid && !timed_out) begin
         @(negedge clk);
         cycles++;
         if (cycles > 200) timed_out = 1'b1;
      end
      while (accepted < PKT_TARGET && !timed_out) begin
         drive_cycle();
         @(negedge clk);
         cycles++;
         if (cycles > RUN_LIMIT) timed_out = 1'b1;
      end
      far_jmp   = '0;
      dec_ready = 1'b0;
      if (timed_out) begin
         $display("timeout: fetch stage stopped delivering packets");
      end
      $display("packets checked %0d, errors %0d, cycles %0d", accepted, errors, cycles);
      if (errors == 0 && !timed_out) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verification/tb_ifetch_bus.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction bus model with a 256 word
// program image and random valid gaps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module tb_ifetch_bus
   import cpu_cfg_pkg::*;
#(
   parameter logic [ADDR_W-1:0] RESET_VECTOR = 32'h0000_0100, // byte address presented after reset
   parameter int                STALL_LEVEL  = 52             // out of 256, chance of a gap
)(
   input  wire logic              clk,
   input  wire logic              arst_n,
   input  wire logic              ibus_ready,
   input  wire logic [ADDR_W-1:0] ibus_addr,  // byte address of the word wanted next
   output logic                   ibus_valid,
   output logic [INSN_W-1:0]      ibus_insn
);

   // program image, written by the testbench top before reset is released
   logic [INSN_W-1:0] image [0:255];

   logic [PC_W-1:0] cur_pc;  // word address of the word being presented
   logic            started; // set on the first edge out of reset
   int              seed;

   initial begin
      seed = 32'h6b1d034f;
   end

   // follow the fetch stage, the next word is whatever it asked for on the transfer edge
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cur_pc  <= RESET_VECTOR[ADDR_W-1:2];
         started <= 1'b0;
      end else begin
         started <= 1'b1;
         if (ibus_valid && ibus_ready) begin
            cur_pc <= ibus_addr[ADDR_W-1:2];
         end
      end
   end

   // valid is driven on the falling edge and drops at random
   always @(negedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ibus_valid <= 1'b0;
      end else begin
         ibus_valid <= started && (($random(seed) & 32'hff) >= STALL_LEVEL);
      end
   end

   // the image wraps every 256 words, only the low address bits select
   assign ibus_insn = image[cur_pc[7:0]];

endmodule

`default_nettype wire
